// File: common/msx_cfg.svh
`ifndef MSX_CFG_SVH
`define MSX_CFG_SVH

// External RAM, byte addressed
`define MSX_RAM_AW 27

// Z80 address space
`define MSX_CPU_AW 16

// 16 KB pages, four per 64 KB space
`define MSX_PAGE_BITS 14

// 8 KB mapper banks
`define MSX_BANK_BITS 13

// Primary slot register
`define MSX_SLOT_PORT 8'hA8

// ASCII8 bank value bit that maps the bank onto SRAM
`define MSX_SRAM_BIT 7

`endif

// File: common/bus_pkg.sv
`include "msx_cfg.svh"

package bus_pkg;

    // One Z80 cycle as seen by the slot logic
    typedef struct packed {
        logic [`MSX_CPU_AW-1:0] addr;
        logic [7:0]             data;  // Write data
        logic                   mreq;  // Memory strobe, one cycle
        logic                   iorq;  // I/O strobe, one cycle
        logic                   wr;    // Write when set
    } cpu_bus_t;

    // Request from a mapper towards external memory
    typedef struct packed {
        logic                   ram_cs;
        logic                   sram_cs;
        logic                   rnw;
        logic [`MSX_RAM_AW-1:0] addr;  // Offset from the region base
    } mem_req_t;

    // No access, bus left in read
    localparam mem_req_t req_idle = '{
        ram_cs:  1'b0,
        sram_cs: 1'b0,
        rnw:     1'b1,
        addr:    '0
    };

endpackage

// File: common/msx_pkg.sv
`include "msx_cfg.svh"

package msx_pkg;

    // Cartridge or memory type found in a slot
    typedef enum logic [1:0] {
        MAPPER_NONE   = 2'd0,  // Empty slot, reads FFh
        MAPPER_LINEAR = 2'd1,  // Plain RAM or ROM
        MAPPER_ASCII8 = 2'd2,  // 8 KB banks plus SRAM
        MAPPER_KONAMI = 2'd3   // Konami, no SCC
    } mapper_t;

    // Layout entry, one per primary slot
    typedef struct packed {
        mapper_t    mapper;
        logic [3:0] ref_ram;     // Row in the RAM lookup table
        logic [1:0] ref_sram;    // Row in the SRAM lookup table
        logic [1:0] offset_ram;  // First 16 KB page occupied
        logic       cart_num;    // Cartridge number
    } block_t;

    // RAM region of a slot
    typedef struct packed {
        logic [`MSX_RAM_AW-1:0] addr;  // Base in external RAM
        logic [15:0]            size;  // In 16 KB blocks
        logic                   ro;    // ROM image, writes dropped
    } lookup_ram_t;

    // Battery backed SRAM region
    typedef struct packed {
        logic [`MSX_RAM_AW-1:0] addr;  // Base in external RAM
        logic [15:0]            size;  // Bytes
    } lookup_sram_t;

    // What a mapper is told about the active slot
    typedef struct packed {
        mapper_t     typ;
        logic [24:0] rom_size;    // Bytes
        logic [15:0] sram_size;   // Bytes, zero when absent
        logic        id;
        logic [1:0]  offset_ram;
    } block_info_t;

endpackage

// File: mappers/mapper_ascii8.sv
`timescale 1ns/1ps
`include "msx_cfg.svh"

module mapper_ascii8 (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::cpu_bus_t cpu,
    input  logic              sel,        // This mapper owns the page
    input  logic [24:0]       rom_size,   // Power of two
    input  logic [15:0]       sram_size,
    output bus_pkg::mem_req_t req
);

    logic [7:0]             bank [4];  // 4000h, 6000h, 8000h, A000h windows
    logic                   reg_wr;
    logic                   in_window;
    logic [1:0]             idx;
    logic [7:0]             cur_bank;
    logic                   sram_hit;
    logic [`MSX_RAM_AW-1:0] rom_offset;

    // Register area 6000h to 7FFFh, bits 12:11 pick the bank
    assign reg_wr = cpu.mreq && cpu.wr && (cpu.addr[15:13] == 3'b011);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                bank[i] <= 8'h00;
            end
        end else if (sel && reg_wr) begin
            bank[cpu.addr[12:11]] <= cpu.data;
        end
    end

    // Cartridge space 4000h to BFFFh
    assign in_window = (cpu.addr[15:14] == 2'b01) || (cpu.addr[15:14] == 2'b10);
    assign idx       = 2'(cpu.addr[15:13] - 3'd2);
    assign cur_bank  = bank[idx];

    // Flagged bank maps SRAM, only when the cartridge has any
    assign sram_hit = cur_bank[`MSX_SRAM_BIT] && (sram_size != 16'd0);

    // Bank times 8 KB, wrapped at the ROM size
    assign rom_offset = `MSX_RAM_AW'({cur_bank, cpu.addr[`MSX_BANK_BITS-1:0]})
                      & `MSX_RAM_AW'(rom_size - 25'd1);

    always_comb begin
        req = bus_pkg::req_idle;
        if (cpu.mreq && in_window) begin
            if (sram_hit) begin
                req.sram_cs = 1'b1;
                req.rnw     = !(cpu.wr && !reg_wr);  // Register writes stay reads
                req.addr    = `MSX_RAM_AW'(cpu.addr[`MSX_BANK_BITS-1:0]);
            end else begin
                req.ram_cs = 1'b1;  // ROM, always a read
                req.addr   = rom_offset;
            end
        end
    end

endmodule

// File: mappers/mapper_konami.sv
`timescale 1ns/1ps
`include "msx_cfg.svh"

module mapper_konami (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::cpu_bus_t cpu,
    input  logic              sel,
    input  logic [24:0]       rom_size,
    output bus_pkg::mem_req_t req
);

    logic [7:0]             bank [1:3];  // Switchable windows, 4000h fixed to 0
    logic                   reg_wr;
    logic                   in_window;
    logic [1:0]             idx;
    logic [7:0]             cur_bank;
    logic [`MSX_RAM_AW-1:0] rom_offset;

    // Write anywhere in 6000h, 8000h or A000h window loads its bank
    assign reg_wr = cpu.mreq && cpu.wr
                 && (cpu.addr[15:13] >= 3'b011) && (cpu.addr[15:13] <= 3'b101);

    assign idx = 2'(cpu.addr[15:13] - 3'd2);

    always_ff @(posedge clk) begin
        if (rst) begin
            bank[1] <= 8'd1;
            bank[2] <= 8'd2;
            bank[3] <= 8'd3;
        end else if (sel && reg_wr) begin
            bank[idx] <= cpu.data;  // idx is 1 to 3 here
        end
    end

    assign in_window = (cpu.addr[15:14] == 2'b01) || (cpu.addr[15:14] == 2'b10);
    assign cur_bank  = (idx == 2'd0) ? 8'd0 : bank[idx];

    // Wrap at the ROM size
    assign rom_offset = `MSX_RAM_AW'({cur_bank, cpu.addr[`MSX_BANK_BITS-1:0]})
                      & `MSX_RAM_AW'(rom_size - 25'd1);

    always_comb begin
        req = bus_pkg::req_idle;
        if (cpu.mreq && in_window) begin
            req.ram_cs = 1'b1;  // rnw stays high
            req.addr   = rom_offset;
        end
    end

endmodule

// File: mappers/mappers.sv
`timescale 1ns/1ps
`include "msx_cfg.svh"

module mappers (
    input  logic                 clk,
    input  logic                 rst,
    input  bus_pkg::cpu_bus_t    cpu,
    input  msx_pkg::block_info_t block_info,
    input  logic [7:0]           ram_dout,
    output bus_pkg::mem_req_t    req,          // Request of the active mapper
    output logic [7:0]           mapper_data   // Data back to the CPU
);

    bus_pkg::mem_req_t      req_linear;
    bus_pkg::mem_req_t      req_ascii8;
    bus_pkg::mem_req_t      req_konami;
    logic                   sel_ascii8;
    logic                   sel_konami;
    logic [`MSX_RAM_AW-1:0] lin_offset;
    logic                   lin_hit;

    // Bank registers move only in the slot that is addressed
    assign sel_ascii8 = (block_info.typ == msx_pkg::MAPPER_ASCII8);
    assign sel_konami = (block_info.typ == msx_pkg::MAPPER_KONAMI);

    // Linear region starts at offset_ram pages, negative wraps to a miss
    assign lin_offset = `MSX_RAM_AW'(cpu.addr)
                      - (`MSX_RAM_AW'(block_info.offset_ram) << `MSX_PAGE_BITS);
    assign lin_hit    = cpu.mreq && (lin_offset < `MSX_RAM_AW'(block_info.rom_size));

    always_comb begin
        req_linear        = bus_pkg::req_idle;
        req_linear.ram_cs = lin_hit;
        req_linear.rnw    = !(lin_hit && cpu.wr);
        req_linear.addr   = lin_hit ? lin_offset : '0;
    end

    mapper_ascii8 mapper_ascii8_inst (
        .clk       (clk),
        .rst       (rst),
        .cpu       (cpu),
        .sel       (sel_ascii8),
        .rom_size  (block_info.rom_size),
        .sram_size (block_info.sram_size),
        .req       (req_ascii8)
    );

    mapper_konami mapper_konami_inst (
        .clk      (clk),
        .rst      (rst),
        .cpu      (cpu),
        .sel      (sel_konami),
        .rom_size (block_info.rom_size),
        .req      (req_konami)
    );

    always_comb begin
        case (block_info.typ)
            msx_pkg::MAPPER_LINEAR: req = req_linear;
            msx_pkg::MAPPER_ASCII8: req = req_ascii8;
            msx_pkg::MAPPER_KONAMI: req = req_konami;
            default:                req = bus_pkg::req_idle;  // Empty slot
        endcase
    end

    // Open bus reads FFh
    assign mapper_data = (req.ram_cs || req.sram_cs) ? ram_dout : 8'hFF;

endmodule

// File: source/msx_slots.sv
`timescale 1ns/1ps
`include "msx_cfg.svh"

module msx_slots (
    input  logic                   clk,
    input  logic                   rst,
    input  bus_pkg::cpu_bus_t      cpu,
    input  msx_pkg::block_t        active_block,  // Layout of the selected slot
    input  msx_pkg::lookup_ram_t   active_ram,    // Its RAM region
    input  msx_pkg::lookup_sram_t  active_sram,   // Its SRAM region
    input  logic [7:0]             ram_dout,
    output logic [7:0]             data,
    output logic [`MSX_RAM_AW-1:0] ram_addr,
    output logic [7:0]             ram_din,
    output logic                   ram_rnw,
    output logic                   sdram_ce
);

    msx_pkg::block_info_t block_info;
    bus_pkg::mem_req_t    req;
    logic [7:0]           mapper_data;

    // Mapper view of the slot
    assign block_info.typ        = active_block.mapper;
    assign block_info.rom_size   = 25'(active_ram.size) << `MSX_PAGE_BITS;  // Blocks to bytes
    assign block_info.sram_size  = active_sram.size;
    assign block_info.id         = active_block.cart_num;
    assign block_info.offset_ram = active_block.offset_ram;

    mappers mappers_inst (
        .clk         (clk),
        .rst         (rst),
        .cpu         (cpu),
        .block_info  (block_info),
        .ram_dout    (ram_dout),
        .req         (req),
        .mapper_data (mapper_data)
    );

    // SRAM region wins when the mapper asks for it
    assign ram_addr = (req.sram_cs ? active_sram.addr : active_ram.addr) + req.addr;

    // Read only regions never see a write
    assign ram_rnw = req.rnw | (req.ram_cs & active_ram.ro);

    assign sdram_ce = req.ram_cs | req.sram_cs;
    assign ram_din  = cpu.data;  // Straight from the CPU
    assign data     = mapper_data;

endmodule

// File: source/slot_select.sv
`timescale 1ns/1ps
`include "msx_cfg.svh"

module slot_select (
    input  logic                  clk,
    input  logic                  rst,
    input  bus_pkg::cpu_bus_t     cpu,
    input  msx_pkg::block_t       slot_layout [4],
    input  msx_pkg::lookup_ram_t  ram_table [16],
    input  msx_pkg::lookup_sram_t sram_table [4],
    output msx_pkg::block_t       active_block,
    output msx_pkg::lookup_ram_t  active_ram,
    output msx_pkg::lookup_sram_t active_sram
);

    logic [7:0] primary;  // Port A8h, two bits per page
    logic [1:0] page;
    logic [1:0] slot;
    logic       port_wr;

    // Only the low byte of the I/O address is decoded
    assign port_wr = cpu.iorq && cpu.wr && (cpu.addr[7:0] == `MSX_SLOT_PORT);

    always_ff @(posedge clk) begin
        if (rst) begin
            primary <= 8'h00;  // Everything in slot 0
        end else if (port_wr) begin
            primary <= cpu.data;
        end
    end

    // Page number from the top address bits
    assign page = cpu.addr[`MSX_CPU_AW-1:`MSX_PAGE_BITS];

    // Field for that page
    assign slot = primary[{page, 1'b0} +: 2];

    // Chained table lookups, all combinational
    assign active_block = slot_layout[slot];
    assign active_ram   = ram_table[active_block.ref_ram];
    assign active_sram  = sram_table[active_block.ref_sram];

endmodule

// File: source/msx_slot_system.sv
`timescale 1ns/1ps
`include "msx_cfg.svh"

module msx_slot_system (
    input  logic                   clk,
    input  logic                   rst,
    input  bus_pkg::cpu_bus_t      cpu,               // CPU cycle
    input  msx_pkg::block_t        slot_layout [4],   // One entry per primary slot
    input  msx_pkg::lookup_ram_t   ram_table [16],    // RAM regions
    input  msx_pkg::lookup_sram_t  sram_table [4],    // SRAM regions
    input  logic [7:0]             ram_dout,          // Read data from RAM
    output logic [7:0]             data,              // Read data to CPU
    output logic [`MSX_RAM_AW-1:0] ram_addr,
    output logic [7:0]             ram_din,
    output logic                   ram_rnw,
    output logic                   sdram_ce
);

    // Configuration of the slot behind the addressed page
    msx_pkg::block_t       active_block;
    msx_pkg::lookup_ram_t  active_ram;
    msx_pkg::lookup_sram_t active_sram;

    slot_select slot_select_inst (
        .clk          (clk),
        .rst          (rst),
        .cpu          (cpu),
        .slot_layout  (slot_layout),
        .ram_table    (ram_table),
        .sram_table   (sram_table),
        .active_block (active_block),
        .active_ram   (active_ram),
        .active_sram  (active_sram)
    );

    // Mappers and address translation
    msx_slots msx_slots_inst (
        .clk          (clk),
        .rst          (rst),
        .cpu          (cpu),
        .active_block (active_block),
        .active_ram   (active_ram),
        .active_sram  (active_sram),
        .ram_dout     (ram_dout),
        .data         (data),
        .ram_addr     (ram_addr),
        .ram_din      (ram_din),
        .ram_rnw      (ram_rnw),
        .sdram_ce     (sdram_ce)
    );

endmodule

// File: sim/slot_checker.sv
`timescale 1ns/1ps
`include "msx_cfg.svh"

module slot_checker (
    input  logic                   clk,
    input  bus_pkg::cpu_bus_t      cpu,       // Strobes mark the rows
    input  logic [7:0]             data,
    input  logic [`MSX_RAM_AW-1:0] ram_addr,
    input  logic [7:0]             ram_din,
    input  logic                   sdram_ce,
    input  logic                   ram_rnw,
    input  logic [`MSX_RAM_AW-1:0] exp_addr,
    input  logic [7:0]             exp_din,   // CPU write data of the row
    input  logic                   exp_en,
    input  logic                   exp_rnw,
    input  logic [7:0]             exp_data,
    input  int                     row_num,
    output int                     checked_count,
    output int                     fail_count
);

    logic row_ok;

    initial begin
        checked_count = 0;
        fail_count    = 0;
        row_ok        = 1'b1;
    end

    // Falling edge, inputs were driven on the rising one
    always @(negedge clk) begin
        if (cpu.mreq || cpu.iorq) begin
            row_ok = (data === exp_data)
                  && (ram_addr === exp_addr)
                  && (ram_din === exp_din)
                  && (sdram_ce === exp_en)
                  && (ram_rnw === exp_rnw);
            checked_count = checked_count + 1;
            if (row_ok) begin
                $display("Row %0d passed: addr %h ce %b rnw %b data %h",
                         row_num, ram_addr, sdram_ce, ram_rnw, data);
            end else begin
                fail_count = fail_count + 1;
                $display("FAILED at %0d ns: row %0d cpu addr %h, got addr %h ce %b rnw %b data %h",
                         $time, row_num, cpu.addr, ram_addr, sdram_ce, ram_rnw, data);
                $display("    got din %h, expected addr %h ce %b rnw %b data %h din %h",
                         ram_din, exp_addr, exp_en, exp_rnw, exp_data, exp_din);
            end
        end
    end

endmodule

// File: sim/tb_msx_slot_system.sv
`timescale 1ns/1ps
`include "msx_cfg.svh"

module tb_msx_slot_system;

    localparam int NUM_ROWS       = 31;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 4 + 60;  // Twice the two cycles per row, plus reset

    // OP_RO_WR is a memory write with the slot 0 RAM entry marked read only
    typedef enum logic [1:0] {OP_IO_WR, OP_MEM_WR, OP_MEM_RD, OP_RO_WR} op_t;

    typedef struct packed {
        op_t                    op;
        logic [15:0]            addr;
        logic [7:0]             wdata;
        logic [`MSX_RAM_AW-1:0] exp_addr;
        logic                   exp_en;    // Expected sdram_ce
        logic                   exp_rnw;
        logic [7:0]             exp_data;
    } row_t;

    logic                   clk;
    logic                   rst;
    bus_pkg::cpu_bus_t      cpu;
    msx_pkg::block_t        slot_layout [4];
    msx_pkg::lookup_ram_t   ram_table [16];
    msx_pkg::lookup_sram_t  sram_table [4];
    logic [7:0]             ram_dout;
    logic [7:0]             data;
    logic [`MSX_RAM_AW-1:0] ram_addr;
    logic [7:0]             ram_din;
    logic                   ram_rnw;
    logic                   sdram_ce;
    row_t                   rows [NUM_ROWS];
    row_t                   cur;  // Row on the bus right now
    int                     row_fill;
    int                     row_num;
    int                     cycle_count;
    int                     checked_count;
    int                     fail_count;
    int                     seed_dummy;

    // RAM model, data follows from the address
    function automatic logic [7:0] model_byte(input logic [`MSX_RAM_AW-1:0] a);
        return a[7:0] ^ a[15:8];
    endfunction

    assign ram_dout = model_byte(ram_addr);

    msx_slot_system msx_slot_system_inst (
        .clk         (clk),
        .rst         (rst),
        .cpu         (cpu),
        .slot_layout (slot_layout),
        .ram_table   (ram_table),
        .sram_table  (sram_table),
        .ram_dout    (ram_dout),
        .data        (data),
        .ram_addr    (ram_addr),
        .ram_din     (ram_din),
        .ram_rnw     (ram_rnw),
        .sdram_ce    (sdram_ce)
    );

    slot_checker slot_checker_inst (
        .clk           (clk),
        .cpu           (cpu),
        .data          (data),
        .ram_addr      (ram_addr),
        .ram_din       (ram_din),
        .sdram_ce      (sdram_ce),
        .ram_rnw       (ram_rnw),
        .exp_addr      (cur.exp_addr),
        .exp_din       (cur.wdata),
        .exp_en        (cur.exp_en),
        .exp_rnw       (cur.exp_rnw),
        .exp_data      (cur.exp_data),
        .row_num       (row_num),
        .checked_count (checked_count),
        .fail_count    (fail_count)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    // Expected data comes from the RAM model, FFh on open bus
    task automatic add_row(input op_t op, input logic [15:0] addr, input logic [7:0] wdata,
                           input logic [`MSX_RAM_AW-1:0] exp_addr, input logic exp_en,
                           input logic exp_rnw);
        rows[row_fill] = '{op: op, addr: addr, wdata: wdata, exp_addr: exp_addr,
                           exp_en: exp_en, exp_rnw: exp_rnw,
                           exp_data: exp_en ? model_byte(exp_addr) : 8'hFF};
        row_fill++;
    endtask

    task automatic configure_slots();
        for (int i = 0; i < 16; i++) begin
            ram_table[i] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            sram_table[i] = '0;
        end
        slot_layout[0] = '{mapper: msx_pkg::MAPPER_LINEAR, ref_ram: 4'd0, ref_sram: 2'd0,
                           offset_ram: 2'd0, cart_num: 1'b0};
        slot_layout[1] = '{mapper: msx_pkg::MAPPER_ASCII8, ref_ram: 4'd1, ref_sram: 2'd1,
                           offset_ram: 2'd0, cart_num: 1'b0};
        slot_layout[2] = '{mapper: msx_pkg::MAPPER_KONAMI, ref_ram: 4'd2, ref_sram: 2'd0,
                           offset_ram: 2'd0, cart_num: 1'b1};
        slot_layout[3] = '{mapper: msx_pkg::MAPPER_NONE, ref_ram: 4'd3, ref_sram: 2'd0,
                           offset_ram: 2'd0, cart_num: 1'b0};
        ram_table[0]  = '{addr: 27'h0100000, size: 16'd4, ro: 1'b0};  // 64 KB main RAM
        ram_table[1]  = '{addr: 27'h0200000, size: 16'd8, ro: 1'b1};  // ASCII8 ROM, 128 KB
        ram_table[2]  = '{addr: 27'h0300000, size: 16'd8, ro: 1'b1};  // Konami ROM, 128 KB
        sram_table[1] = '{addr: 27'h0400000, size: 16'h2000};         // 8 KB SRAM
    endtask

    task automatic build_table();
        row_fill = 0;
        add_row(OP_MEM_RD, 16'h0000, 8'h00, 27'h0100000, 1'b1, 1'b1);  // All pages in slot 0
        add_row(OP_MEM_RD, 16'h1234, 8'h00, 27'h0101234, 1'b1, 1'b1);
        add_row(OP_MEM_WR, 16'h2345, 8'($urandom), 27'h0102345, 1'b1, 1'b0);
        add_row(OP_MEM_RD, 16'hC321, 8'h00, 27'h010C321, 1'b1, 1'b1);
        add_row(OP_IO_WR, 16'h00A8, 8'h97, 27'h0100000, 1'b0, 1'b1);   // Pages 3,1,1,2 from page 0
        add_row(OP_MEM_RD, 16'h0100, 8'h00, 27'h0000000, 1'b0, 1'b1);  // Empty slot
        add_row(OP_MEM_RD, 16'hC000, 8'h00, 27'h0300000, 1'b0, 1'b1);  // Konami outside window
        add_row(OP_MEM_RD, 16'h4000, 8'h00, 27'h0200000, 1'b1, 1'b1);
        add_row(OP_MEM_RD, 16'hA123, 8'h00, 27'h0200123, 1'b1, 1'b1);
        add_row(OP_MEM_WR, 16'h6000, 8'h05, 27'h0200000, 1'b1, 1'b1);  // Bank 0 to 5
        add_row(OP_MEM_RD, 16'h4010, 8'h00, 27'h020A010, 1'b1, 1'b1);
        add_row(OP_MEM_WR, 16'h7800, 8'h13, 27'h0201800, 1'b1, 1'b1);  // Bank 3 to 19
        add_row(OP_MEM_RD, 16'hA005, 8'h00, 27'h0206005, 1'b1, 1'b1);  // 19 wraps to 3
        add_row(OP_MEM_WR, 16'h7000, 8'h80, 27'h0201000, 1'b1, 1'b1);  // Bank 2 onto SRAM
        add_row(OP_MEM_RD, 16'h8123, 8'h00, 27'h0400123, 1'b1, 1'b1);
        add_row(OP_MEM_WR, 16'h9ABC, 8'($urandom), 27'h0401ABC, 1'b1, 1'b0);
        add_row(OP_MEM_WR, 16'h5000, 8'($urandom), 27'h020B000, 1'b1, 1'b1);  // ROM write
        add_row(OP_MEM_WR, 16'h6800, 8'h80, 27'h0200800, 1'b1, 1'b1);  // Bank 1 onto SRAM
        add_row(OP_MEM_WR, 16'h6800, 8'h00, 27'h0400800, 1'b1, 1'b1);  // Register hit in SRAM
        add_row(OP_IO_WR, 16'h00A8, 8'h28, 27'h0000000, 1'b0, 1'b1);   // Konami in pages 1,2
        add_row(OP_MEM_RD, 16'h4123, 8'h00, 27'h0300123, 1'b1, 1'b1);  // Fixed bank 0
        add_row(OP_MEM_RD, 16'h6123, 8'h00, 27'h0302123, 1'b1, 1'b1);
        add_row(OP_MEM_RD, 16'hA456, 8'h00, 27'h0306456, 1'b1, 1'b1);
        add_row(OP_MEM_WR, 16'h8000, 8'h0A, 27'h0304000, 1'b1, 1'b1);  // Bank 2 to 10
        add_row(OP_MEM_RD, 16'h8765, 8'h00, 27'h0314765, 1'b1, 1'b1);
        add_row(OP_MEM_WR, 16'hA000, 8'h11, 27'h0306000, 1'b1, 1'b1);  // Bank 3 to 17
        add_row(OP_MEM_RD, 16'hBFFF, 8'h00, 27'h0303FFF, 1'b1, 1'b1);  // 17 wraps to 1
        add_row(OP_MEM_WR, 16'h4800, 8'($urandom), 27'h0300800, 1'b1, 1'b1);
        add_row(OP_MEM_WR, 16'h3FFE, 8'($urandom), 27'h0103FFE, 1'b1, 1'b0);
        add_row(OP_RO_WR, 16'h3FFF, 8'($urandom), 27'h0103FFF, 1'b1, 1'b1);  // Write dropped
        add_row(OP_MEM_RD, 16'hC000, 8'h00, 27'h010C000, 1'b1, 1'b1);
    endtask

    initial begin
        seed_dummy = $urandom(81206);
        clk         = 1'b0;
        rst         = 1'b1;
        cpu         = '0;
        cur         = '0;
        row_num     = 0;
        cycle_count = 0;
        configure_slots();
        build_table();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < row_fill; i++) begin
            @(posedge clk);
            cur     <= rows[i];
            row_num <= i;
            ram_table[0].ro <= (rows[i].op == OP_RO_WR);  // Main RAM as ROM for this row
            cpu     <= '{addr: rows[i].addr, data: rows[i].wdata,
                         mreq: rows[i].op != OP_IO_WR, iorq: rows[i].op == OP_IO_WR,
                         wr: rows[i].op != OP_MEM_RD};
            @(posedge clk);
            cpu <= '0;  // Idle cycle, register writes settle
        end
        repeat (2) @(posedge clk);
        $display("Rows checked: %0d of %0d, failed: %0d", checked_count, NUM_ROWS, fail_count);
        if (fail_count == 0 && checked_count == NUM_ROWS && row_fill == NUM_ROWS) begin
            $display("Simulation completed successfully");
        end else begin
            if (checked_count != NUM_ROWS) begin
                $display("Checker saw %0d strobes but the table holds %0d rows",
                         checked_count, NUM_ROWS);
            end
            $display("Simulation failed");
        end
        $finish;
    end

    // Run cannot hang
    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: msx_slot_system.f
+incdir+common
common/bus_pkg.sv
common/msx_pkg.sv
mappers/mapper_ascii8.sv
mappers/mapper_konami.sv
mappers/mappers.sv
source/msx_slots.sv
source/slot_select.sv
source/msx_slot_system.sv
sim/slot_checker.sv
sim/tb_msx_slot_system.sv
